// File: dv/tb_async_fifo.sv
`timescale 1ns/1ps

module tb_async_fifo;

  localparam int DW     = fifo_cfg_pkg::DEF_DATA_WIDTH;
  localparam int FD     = fifo_cfg_pkg::DEF_FIFO_DEPTH;
  localparam int AFL    = fifo_cfg_pkg::DEF_AFULL_LEVEL;
  localparam int AEL    = fifo_cfg_pkg::DEF_AEMPTY_LEVEL;
  localparam int N_RAND = 200;
  // Twice the words of all tests, 20 rd_clk cycles per word
  localparam int CYCLE_LIMIT = 2 * (N_RAND + FD + 1) * 20;

  logic          wr_clk = 1'b0;
  logic          rd_clk = 1'b0;
  logic          wr_rst_n, rd_rst_n, in_req, in_ack, full, afull;
  logic          out_req, out_ack, empty, aempty;
  logic [DW-1:0] in_data, out_data;
  logic [DW-1:0] ref_q[$];
  logic [DW-1:0] wr_word[N_RAND];
  int            wr_gap[N_RAND];
  int            rd_gap[N_RAND];
  logic [31:0]   lfsr = 32'hba79;
  logic [31:0]   rnd;
  int            errors = 0;
  int            compared = 0;
  int            cycles = 0;
  int            fill = 0;
  int            mark = 0;
  int            levels[4] = '{AFL, AFL - 1, AEL + 1, AEL};

  async_fifo_top #(
    .DATA_WIDTH   (DW),
    .FIFO_DEPTH   (FD),
    .AFULL_LEVEL  (AFL),
    .AEMPTY_LEVEL (AEL),
    .SYNC_STAGES  (fifo_cfg_pkg::DEF_SYNC_STAGES)
  ) u_dut (.*);

  always #2 rd_clk = ~rd_clk;
  always #3 wr_clk = ~wr_clk;

  // ==========================================================================
  // Random source and reference model
  // ==========================================================================

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Settled flags for a given fill count, as full afull empty aempty
  function automatic logic [3:0] expected_flags(input int fill_cnt);
    return {fill_cnt == FD, fill_cnt >= AFL, fill_cnt == 0, fill_cnt <= AEL};
  endfunction

  function automatic logic [DW-1:0] next_expected();
    return ref_q.pop_front();
  endfunction

  // ==========================================================================
  // Handshake drivers
  // ==========================================================================

  task automatic wr_tick();
    @(posedge wr_clk);
    #1;
  endtask

  task automatic rd_tick();
    @(posedge rd_clk);
    #1;
  endtask

  // Request already up, wait for the ack and return to zero
  task automatic finish_put(input logic [DW-1:0] word);
    do wr_tick(); while (in_ack !== 1'b1);
    ref_q.push_back(word);
    in_req = 1'b0;
    do wr_tick(); while (in_ack !== 1'b0);
  endtask

  task automatic put_word(input logic [DW-1:0] word, input int gap);
    repeat (gap + 1) wr_tick();
    in_req  = 1'b1;
    in_data = word;
    finish_put(word);
  endtask

  task automatic get_word(input int gap);
    do rd_tick(); while (out_req !== 1'b1);
    repeat (gap) rd_tick();
    out_ack = 1'b1;
    do rd_tick(); while (out_req !== 1'b0);
    out_ack = 1'b0;
  endtask

  task automatic check_levels();
    if ({full, afull, empty, aempty} !== expected_flags(fill)) begin
      $display("error at %0t ns: full afull empty aempty %b, expected %b at fill %0d",
               $time, {full, afull, empty, aempty}, expected_flags(fill), fill);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %s with %0d errors", name, (errors == mark) ? "passed" : "failed",
             errors - mark);
    mark = errors;
  endtask

  // Both req and ack high at the falling edge marks a completed transfer
  always @(negedge rd_clk) begin : compare_out
    logic [DW-1:0] exp_word;
    if (rd_rst_n && out_req && out_ack) begin
      if (ref_q.size() == 0) begin
        $display("output word %h at %0t ns was never written into the FIFO", out_data, $time);
        errors++;
      end else begin
        exp_word = next_expected();
        compared++;
        if (out_data !== exp_word) begin
          $display("error at %0t ns: out_data %h, expected %h", $time, out_data, exp_word);
          errors++;
        end
      end
    end
  end

  always @(posedge rd_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d rd_clk cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    in_req   = 1'b0;
    in_data  = '0;
    out_ack  = 1'b0;
    for (int i = 0; i < N_RAND; i++) begin
      rnd        = rand_bits(DW);
      wr_word[i] = rnd[DW-1:0];
      wr_gap[i]  = int'(rand_bits(2));
      rd_gap[i]  = int'(rand_bits(3));
    end
    repeat (3) @(posedge rd_clk);
    #1;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    repeat (2) rd_tick();
    check_levels();
    if (in_ack !== 1'b0 || out_req !== 1'b0) begin
      $display("error at %0t ns: in_ack %b out_req %b after reset", $time, in_ack, out_req);
      errors++;
    end
    end_test("reset state");

    fork
      for (int i = 0; i < N_RAND; i++) begin
        put_word(wr_word[i], wr_gap[i]);
      end
      for (int i = 0; i < N_RAND; i++) begin
        get_word(rd_gap[i]);
      end
    join
    if (ref_q.size() != 0) begin
      $display("%0d written words never came out of the FIFO", ref_q.size());
      errors++;
    end
    end_test("order and integrity");

    // Consumer holds out_ack low, so the FIFO fills up
    for (int i = 0; i < FD; i++) begin
      rnd = rand_bits(DW);
      put_word(rnd[DW-1:0], 0);
    end
    rnd = rand_bits(DW);
    wr_tick();
    in_req  = 1'b1;
    in_data = rnd[DW-1:0];
    repeat (10) begin
      wr_tick();
      if (in_ack !== 1'b0) begin
        $display("error at %0t ns: in_ack high while the FIFO is full", $time);
        errors++;
      end
    end
    fill = FD;
    check_levels();
    // One read makes room for the waiting word
    fork
      finish_put(rnd[DW-1:0]);
      get_word(0);
    join
    end_test("full back-pressure");

    foreach (levels[k]) begin
      repeat (fill - levels[k]) get_word(0);
      fill = levels[k];
      repeat (10) wr_tick();
      check_levels();
    end
    end_test("almost levels");

    repeat (fill) get_word(0);
    fill = 0;
    repeat (10) wr_tick();
    check_levels();
    repeat (10) begin
      rd_tick();
      if (out_req !== 1'b0) begin
        $display("error at %0t ns: out_req high with the FIFO drained", $time);
        errors++;
      end
    end
    end_test("drain");

    $display("words compared %0d, errors %0d", compared, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
rtl/fifo_cfg_pkg.sv
rtl/fifo_hs_pkg.sv
rtl/fifo_wr_side.sv
rtl/fifo_dpram.sv
rtl/gray_ptr_sync.sv
rtl/fifo_rd_side.sv
rtl/async_fifo_top.sv
dv/tb_async_fifo.sv

// File: rtl/async_fifo_top.sv
`timescale 1ns/1ps

module async_fifo_top #(
  parameter  int DATA_WIDTH   = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter  int FIFO_DEPTH   = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  parameter  int AFULL_LEVEL  = fifo_cfg_pkg::DEF_AFULL_LEVEL,
  parameter  int AEMPTY_LEVEL = fifo_cfg_pkg::DEF_AEMPTY_LEVEL,
  parameter  int SYNC_STAGES  = fifo_cfg_pkg::DEF_SYNC_STAGES
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  in_req,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ack,
  output logic                  full,
  output logic                  afull,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  output logic                  out_req,
  output logic [DATA_WIDTH-1:0] out_data,
  input  logic                  out_ack,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  ram_wr_en;
  logic [ADDR_WIDTH-1:0] ram_wr_addr;
  logic [DATA_WIDTH-1:0] ram_wr_data;
  logic [ADDR_WIDTH-1:0] ram_rd_addr;
  logic [DATA_WIDTH-1:0] ram_rd_data;
  logic [ADDR_WIDTH:0]   wr_ptr_gray;
  logic [ADDR_WIDTH:0]   rd_ptr_gray;
  logic [ADDR_WIDTH:0]   wr_ptr_bin_rsync;
  logic [ADDR_WIDTH:0]   rd_ptr_bin_wsync;

  // ==========================================================================
  // Producer domain
  // ==========================================================================

  fifo_wr_side #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .AFULL_LEVEL (AFULL_LEVEL)
  ) u_wr_side (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .in_req           (in_req),
    .in_data          (in_data),
    .in_ack           (in_ack),
    .ram_wr_en        (ram_wr_en),
    .ram_wr_addr      (ram_wr_addr),
    .ram_wr_data      (ram_wr_data),
    .wr_ptr_gray      (wr_ptr_gray),
    .rd_ptr_bin_wsync (rd_ptr_bin_wsync),
    .full             (full),
    .afull            (afull)
  );

  // ==========================================================================
  // Storage and pointer crossings
  // ==========================================================================

  fifo_dpram #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dpram (
    .wr_clk      (wr_clk),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .ram_wr_data (ram_wr_data),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data)
  );

  gray_ptr_sync #(
    .PTR_WIDTH   (ADDR_WIDTH + 1),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_wsync_to_rd (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .ptr_gray (wr_ptr_gray),
    .ptr_bin  (wr_ptr_bin_rsync)
  );

  gray_ptr_sync #(
    .PTR_WIDTH   (ADDR_WIDTH + 1),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_rsync_to_wr (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .ptr_gray (rd_ptr_gray),
    .ptr_bin  (rd_ptr_bin_wsync)
  );

  // Consumer domain
  fifo_rd_side #(
    .DATA_WIDTH   (DATA_WIDTH),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) u_rd_side (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .out_req          (out_req),
    .out_data         (out_data),
    .out_ack          (out_ack),
    .ram_rd_addr      (ram_rd_addr),
    .ram_rd_data      (ram_rd_data),
    .rd_ptr_gray      (rd_ptr_gray),
    .wr_ptr_bin_rsync (wr_ptr_bin_rsync),
    .empty            (empty),
    .aempty           (aempty)
  );

endmodule

// File: rtl/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

  // ==========================================================================
  // Default FIFO geometry
  // ==========================================================================

  // Width of one data word
  parameter int DEF_DATA_WIDTH = 8;

  // Number of entries, power of two only
  parameter int DEF_FIFO_DEPTH = 16;

  // ==========================================================================
  // Flag thresholds and crossing depth
  // ==========================================================================

  // afull is set when the fill count is at or above this level
  parameter int DEF_AFULL_LEVEL = 12;

  // aempty is set when the fill count is at or below this level
  parameter int DEF_AEMPTY_LEVEL = 2;

  // Flip-flops in each pointer synchronizer chain
  parameter int DEF_SYNC_STAGES = 2;

endpackage

// File: rtl/fifo_dpram.sv
`timescale 1ns/1ps

module fifo_dpram #(
  parameter  int DATA_WIDTH = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter  int FIFO_DEPTH = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  ram_wr_en,
  input  logic [ADDR_WIDTH-1:0] ram_wr_addr,
  input  logic [DATA_WIDTH-1:0] ram_wr_data,
  input  logic [ADDR_WIDTH-1:0] ram_rd_addr,
  output logic [DATA_WIDTH-1:0] ram_rd_data
);

  // ==========================================================================
  // Storage array
  // ==========================================================================

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // Write port in the producer domain
  always_ff @(posedge wr_clk) begin
    if (ram_wr_en) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  // Read port, no clock
  // address comes from a register in the consumer domain
  assign ram_rd_data = mem[ram_rd_addr];

endmodule

// File: rtl/fifo_hs_pkg.sv
package fifo_hs_pkg;

  // ==========================================================================
  // Four-phase handshake state
  // ==========================================================================

  // HS_IDLE     waiting to start a transfer
  // HS_ACTIVE   request and acknowledge phase in progress
  // HS_RELEASE  return-to-zero phase
  typedef enum logic [1:0] {
    HS_IDLE    = 2'b00,
    HS_ACTIVE  = 2'b01,
    HS_RELEASE = 2'b10
  } hs_state_t;

endpackage

// File: rtl/fifo_rd_side.sv
`timescale 1ns/1ps

module fifo_rd_side #(
  parameter  int DATA_WIDTH   = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter  int FIFO_DEPTH   = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  parameter  int AEMPTY_LEVEL = fifo_cfg_pkg::DEF_AEMPTY_LEVEL,
  localparam int ADDR_WIDTH   = $clog2(FIFO_DEPTH)
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  output logic                  out_req,
  output logic [DATA_WIDTH-1:0] out_data,
  input  logic                  out_ack,
  output logic [ADDR_WIDTH-1:0] ram_rd_addr,
  input  logic [DATA_WIDTH-1:0] ram_rd_data,
  output logic [ADDR_WIDTH:0]   rd_ptr_gray,
  input  logic [ADDR_WIDTH:0]   wr_ptr_bin_rsync,
  output logic                  empty,
  output logic                  aempty
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [PTR_W-1:0] AEMPTY_CNT = PTR_W'(AEMPTY_LEVEL);

  fifo_hs_pkg::hs_state_t state;

  logic [PTR_W-1:0] rd_ptr_bin;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [PTR_W-1:0] fill_next;
  logic             rd_fire;
  logic             launch;

  // Consumer took the word, release request and move on
  assign rd_fire     = (state == fifo_hs_pkg::HS_ACTIVE) && out_ack;
  assign launch      = (state == fifo_hs_pkg::HS_IDLE) && !empty;
  assign rd_ptr_next = rd_fire ? rd_ptr_bin + PTR_W'(1) : rd_ptr_bin;
  assign fill_next   = wr_ptr_bin_rsync - rd_ptr_next;

  assign ram_rd_addr = rd_ptr_bin[ADDR_WIDTH-1:0];

  // ==========================================================================
  // Sending handshake
  // ==========================================================================

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state   <= fifo_hs_pkg::HS_IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        fifo_hs_pkg::HS_IDLE: begin
          if (launch) begin
            state   <= fifo_hs_pkg::HS_ACTIVE;
            out_req <= 1'b1;
          end
        end
        fifo_hs_pkg::HS_ACTIVE: begin
          if (rd_fire) begin
            state   <= fifo_hs_pkg::HS_RELEASE;
            out_req <= 1'b0;
          end
        end
        fifo_hs_pkg::HS_RELEASE: begin
          // Wait for the return to zero before the next word
          if (!out_ack) begin
            state <= fifo_hs_pkg::HS_IDLE;
          end
        end
        default: begin
          state   <= fifo_hs_pkg::HS_IDLE;
          out_req <= 1'b0;
        end
      endcase
    end
  end

  // Output word captured as the request goes up
  always_ff @(posedge rd_clk) begin
    if (launch) begin
      out_data <= ram_rd_data;
    end
  end

  // ==========================================================================
  // Read pointer and flags
  // ==========================================================================

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
    end else begin
      rd_ptr_bin  <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
      empty       <= (fill_next == '0);
      aempty      <= (fill_next <= AEMPTY_CNT);
    end
  end

  // A word on offer always lies inside the filled range
  a_no_req_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    out_req |-> (wr_ptr_bin_rsync != rd_ptr_bin)
  );

  // Offered word still matches its RAM entry
  a_out_data_stable: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    out_req |-> (out_data == ram_rd_data)
  );

endmodule

// File: rtl/fifo_wr_side.sv
`timescale 1ns/1ps

module fifo_wr_side #(
  parameter  int DATA_WIDTH  = fifo_cfg_pkg::DEF_DATA_WIDTH,
  parameter  int FIFO_DEPTH  = fifo_cfg_pkg::DEF_FIFO_DEPTH,
  parameter  int AFULL_LEVEL = fifo_cfg_pkg::DEF_AFULL_LEVEL,
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  in_req,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ack,
  output logic                  ram_wr_en,
  output logic [ADDR_WIDTH-1:0] ram_wr_addr,
  output logic [DATA_WIDTH-1:0] ram_wr_data,
  output logic [ADDR_WIDTH:0]   wr_ptr_gray,
  input  logic [ADDR_WIDTH:0]   rd_ptr_bin_wsync,
  output logic                  full,
  output logic                  afull
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [PTR_W-1:0] FULL_CNT  = PTR_W'(FIFO_DEPTH);
  localparam logic [PTR_W-1:0] AFULL_CNT = PTR_W'(AFULL_LEVEL);

  fifo_hs_pkg::hs_state_t state;

  logic [PTR_W-1:0] wr_ptr_bin;
  logic [PTR_W-1:0] wr_ptr_next;
  logic [PTR_W-1:0] fill_next;
  logic             wr_fire;

  // Accept only from idle and only with room left
  assign wr_fire     = (state == fifo_hs_pkg::HS_IDLE) && in_req && !full;
  assign wr_ptr_next = wr_fire ? wr_ptr_bin + PTR_W'(1) : wr_ptr_bin;
  assign fill_next   = wr_ptr_next - rd_ptr_bin_wsync;

  assign ram_wr_en   = wr_fire;
  assign ram_wr_addr = wr_ptr_bin[ADDR_WIDTH-1:0];
  assign ram_wr_data = in_data;

  // ==========================================================================
  // Receiving handshake
  // ==========================================================================

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      state  <= fifo_hs_pkg::HS_IDLE;
      in_ack <= 1'b0;
    end else begin
      case (state)
        fifo_hs_pkg::HS_IDLE: begin
          if (wr_fire) begin
            state  <= fifo_hs_pkg::HS_ACTIVE;
            in_ack <= 1'b1;
          end
        end
        fifo_hs_pkg::HS_ACTIVE: begin
          // Producer has seen the ack and released its request
          if (!in_req) begin
            state <= fifo_hs_pkg::HS_RELEASE;
          end
        end
        fifo_hs_pkg::HS_RELEASE: begin
          state  <= fifo_hs_pkg::HS_IDLE;
          in_ack <= 1'b0;
        end
        default: begin
          state  <= fifo_hs_pkg::HS_IDLE;
          in_ack <= 1'b0;
        end
      endcase
    end
  end

  // ==========================================================================
  // Write pointer and flags
  // ==========================================================================

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_ptr_bin  <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
      full        <= (fill_next == FULL_CNT);
      afull       <= (fill_next >= AFULL_CNT);
    end
  end

  // No write over an entry that is still unread
  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    ram_wr_en |-> ((wr_ptr_bin - rd_ptr_bin_wsync) < FULL_CNT)
  );

  // Producer keeps the word steady until it is acknowledged
  a_in_data_stable: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    (in_req && !in_ack && $past(in_req && !in_ack)) |-> $stable(in_data)
  );

endmodule

// File: rtl/gray_ptr_sync.sv
`timescale 1ns/1ps

module gray_ptr_sync #(
  parameter int PTR_WIDTH   = $clog2(fifo_cfg_pkg::DEF_FIFO_DEPTH) + 1,
  parameter int SYNC_STAGES = fifo_cfg_pkg::DEF_SYNC_STAGES
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [PTR_WIDTH-1:0] ptr_gray,
  output logic [PTR_WIDTH-1:0] ptr_bin
);

  logic [PTR_WIDTH-1:0] sync_q [SYNC_STAGES];
  logic [PTR_WIDTH-1:0] gray_s;

  // Shift chain in the destination clock domain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= ptr_gray;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gray_s = sync_q[SYNC_STAGES-1];

  // Gray to binary, running XOR from the MSB down
  always_comb begin
    ptr_bin[PTR_WIDTH-1] = gray_s[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      ptr_bin[i] = ptr_bin[i+1] ^ gray_s[i];
    end
  end

  a_gray_one_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(gray_s ^ $past(gray_s)) <= 1
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_async_fifo --Mdir obj_dir -o sim_tb -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
